//--- rtl/synthPkg.sv
// -------------------------------------------------------------------
// Audio and DDS definitions shared by the voice path and the mixer.
// Refer to items by package scope, e.g. synthPkg::sampleT.
// -------------------------------------------------------------------
package synthPkg;

   // Sizing of the voice array and accumulator
   localparam int NumVoices  = 4;
   localparam int PhaseWidth = 32;
   localparam int FreqWidth  = 18;
   localparam int FreqShift  = 14;   // Word lands in phase bits 31..14
   localparam int AddrWidth  = 8;    // Top phase bits index the table
   localparam int QuadOffset = 64;   // Quarter of 256 entries, 90 degrees
   localparam int MixShift   = 2;    // Divide by four voices

   typedef logic [PhaseWidth-1:0]   phaseT;
   typedef logic [FreqWidth-1:0]    freqWordT;
   typedef logic [AddrWidth-1:0]    romAddrT;
   typedef logic signed [15:0]      sampleT;    // Two's-complement audio

   // One voice, in-phase and quadrature samples
   typedef struct packed {
      sampleT sine;
      sampleT cosine;
   } voiceOutT;

endpackage

//--- rtl/axiLitePkg.sv
// -------------------------------------------------------------------
// AXI4-Lite channel bundles and the register map of the synthesizer.
// Master side drives axiLiteReqT, slave side answers with axiLiteRspT.
// -------------------------------------------------------------------
package axiLitePkg;

   localparam int BusAddrWidth = 8;
   localparam int BusDataWidth = 32;

   typedef logic [BusAddrWidth-1:0] busAddrT;
   typedef logic [BusDataWidth-1:0] busDataT;
   typedef logic [1:0]              respT;

   localparam respT RespOkay   = 2'd0;
   localparam respT RespSlvErr = 2'd2;

   // Register map, byte addresses
   localparam busAddrT FreqBase   = 8'h00;   // Voice v at FreqBase + 4*v
   localparam busAddrT EnableAddr = 8'h10;   // Low NumVoices bits kept

   typedef struct packed {
      busAddrT awaddr;
      logic    awvalid;
      busDataT wdata;
      logic    wvalid;
      logic    bready;
      busAddrT araddr;
      logic    arvalid;
      logic    rready;
   } axiLiteReqT;

   typedef struct packed {
      logic    awready;
      logic    wready;
      logic    bvalid;
      respT    bresp;
      logic    arready;
      logic    rvalid;
      busDataT rdata;
      respT    rresp;
   } axiLiteRspT;

endpackage

//--- rtl/voiceRegs.sv
// -------------------------------------------------------------------
// AXI4-Lite register slave for the voice array. Holds one tuning word
// per voice and the voice enable mask; reads return the stored values.
// Address and write data are taken together, one transfer at a time.
// -------------------------------------------------------------------
`timescale 1ns/1ns

module voiceRegs (
   input  logic                            AUD_DACLRCK,
   input  logic                            rstN,
   input  axiLitePkg::axiLiteReqT          busReq,
   output axiLitePkg::axiLiteRspT          busRsp,
   output synthPkg::freqWordT              freqWords [synthPkg::NumVoices],
   output logic [synthPkg::NumVoices-1:0]  enableMask
);

   typedef logic [$clog2(synthPkg::NumVoices)-1:0] voiceIdxT;
   typedef enum logic {WrIdle, WrResp} wrStateT;
   typedef enum logic {RdIdle, RdResp} rdStateT;

   wrStateT              wrState;
   rdStateT              rdState;
   axiLitePkg::respT     bresp;
   axiLitePkg::respT     rresp;
   axiLitePkg::busDataT  rdata;
   logic                 wrFire;   // Write accepted this cycle
   logic                 rdFire;   // Read accepted this cycle

   // Word-aligned hit inside the frequency block
   function automatic logic isFreqAddr(axiLitePkg::busAddrT addr);
      return (addr >= axiLitePkg::FreqBase) &&
             (addr < axiLitePkg::FreqBase + 4 * synthPkg::NumVoices) &&
             (addr[1:0] == 2'b00);
   endfunction

   function automatic voiceIdxT freqIndex(axiLitePkg::busAddrT addr);
      return voiceIdxT'((addr - axiLitePkg::FreqBase) >> 2);
   endfunction

   assign wrFire = (wrState == WrIdle) && busReq.awvalid && busReq.wvalid;
   assign rdFire = (rdState == RdIdle) && busReq.arvalid;

   // Response bundle, readies are combinational on the idle state
   always_comb begin
      busRsp         = '0;
      busRsp.awready = wrFire;
      busRsp.wready  = wrFire;
      busRsp.bvalid  = (wrState == WrResp);
      busRsp.bresp   = bresp;
      busRsp.arready = rdFire;
      busRsp.rvalid  = (rdState == RdResp);
      busRsp.rdata   = rdata;
      busRsp.rresp   = rresp;
   end

   // -----------------------------------------------------------------
   // Write channel
   // -----------------------------------------------------------------
   always_ff @(posedge AUD_DACLRCK) begin
      if (!rstN) begin
         wrState    <= WrIdle;
         bresp      <= axiLitePkg::RespOkay;
         freqWords  <= '{default: '0};
         enableMask <= '0;
      end else begin
         case (wrState)
            WrIdle: if (wrFire) begin
               wrState <= WrResp;   // bvalid from this edge on
               bresp   <= axiLitePkg::RespOkay;
               if (isFreqAddr(busReq.awaddr)) begin
                  freqWords[freqIndex(busReq.awaddr)] <=
                     busReq.wdata[synthPkg::FreqWidth-1:0];
               end else if (busReq.awaddr == axiLitePkg::EnableAddr) begin
                  enableMask <= busReq.wdata[synthPkg::NumVoices-1:0];
               end else begin
                  bresp <= axiLitePkg::RespSlvErr;   // Unmapped, no effect
               end
            end
            WrResp: if (busReq.bready) wrState <= WrIdle;
            default: wrState <= WrIdle;
         endcase
      end
   end

   // -----------------------------------------------------------------
   // Read channel
   // -----------------------------------------------------------------
   always_ff @(posedge AUD_DACLRCK) begin
      if (!rstN) begin
         rdState <= RdIdle;
         rresp   <= axiLitePkg::RespOkay;
         rdata   <= '0;
      end else begin
         case (rdState)
            RdIdle: if (rdFire) begin
               rdState <= RdResp;
               rresp   <= axiLitePkg::RespOkay;
               if (isFreqAddr(busReq.araddr)) begin
                  rdata <= axiLitePkg::busDataT'(freqWords[freqIndex(busReq.araddr)]);
               end else if (busReq.araddr == axiLitePkg::EnableAddr) begin
                  rdata <= axiLitePkg::busDataT'(enableMask);
               end else begin
                  rdata <= '0;                        // Unmapped reads as zero
                  rresp <= axiLitePkg::RespSlvErr;
               end
            end
            RdResp: if (busReq.rready) rdState <= RdIdle;   // Data held till then
            default: rdState <= RdIdle;
         endcase
      end
   end

endmodule

//--- rtl/sineRom.sv
// -------------------------------------------------------------------
// 256-point, 16-bit two's-complement sine lookup with one register.
// Only a quarter wave is stored; quadrant logic mirrors and negates.
// -------------------------------------------------------------------
`timescale 1ns/1ns

module sineRom (
   input  logic              AUD_DACLRCK,
   input  synthPkg::romAddrT address,
   output synthPkg::sampleT  sine
);

   logic [6:0]       quarterIdx;   // 0..64 inclusive
   synthPkg::sampleT quarterVal;

   // Quadrants 1 and 3 run backwards through the quarter table
   assign quarterIdx = address[6] ? 7'd64 - {1'b0, address[5:0]}
                                  : {1'b0, address[5:0]};

   // Quarter wave, (2^14-1)*sin(2*pi*n/256)
   always_comb begin
      case (quarterIdx)
         7'd0:    quarterVal = 16'h0000;
         7'd1:    quarterVal = 16'h0192;
         7'd2:    quarterVal = 16'h0323;
         7'd3:    quarterVal = 16'h04b5;
         7'd4:    quarterVal = 16'h0645;
         7'd5:    quarterVal = 16'h07d5;
         7'd6:    quarterVal = 16'h0963;
         7'd7:    quarterVal = 16'h0af0;
         7'd8:    quarterVal = 16'h0c7c;
         7'd9:    quarterVal = 16'h0e05;
         7'd10:   quarterVal = 16'h0f8c;
         7'd11:   quarterVal = 16'h1111;
         7'd12:   quarterVal = 16'h1293;
         7'd13:   quarterVal = 16'h1413;
         7'd14:   quarterVal = 16'h158f;
         7'd15:   quarterVal = 16'h1708;
         7'd16:   quarterVal = 16'h187d;   // 22.5 degrees
         7'd17:   quarterVal = 16'h19ef;
         7'd18:   quarterVal = 16'h1b5c;
         7'd19:   quarterVal = 16'h1cc5;
         7'd20:   quarterVal = 16'h1e2a;
         7'd21:   quarterVal = 16'h1f8b;
         7'd22:   quarterVal = 16'h20e6;
         7'd23:   quarterVal = 16'h223c;
         7'd24:   quarterVal = 16'h238d;
         7'd25:   quarterVal = 16'h24d9;
         7'd26:   quarterVal = 16'h261f;
         7'd27:   quarterVal = 16'h275f;
         7'd28:   quarterVal = 16'h2899;
         7'd29:   quarterVal = 16'h29cc;
         7'd30:   quarterVal = 16'h2afa;
         7'd31:   quarterVal = 16'h2c20;
         7'd32:   quarterVal = 16'h2d40;   // 45 degrees
         7'd33:   quarterVal = 16'h2e59;
         7'd34:   quarterVal = 16'h2f6b;
         7'd35:   quarterVal = 16'h3075;
         7'd36:   quarterVal = 16'h3178;
         7'd37:   quarterVal = 16'h3273;
         7'd38:   quarterVal = 16'h3366;
         7'd39:   quarterVal = 16'h3452;
         7'd40:   quarterVal = 16'h3535;
         7'd41:   quarterVal = 16'h3611;
         7'd42:   quarterVal = 16'h36e4;
         7'd43:   quarterVal = 16'h37ae;
         7'd44:   quarterVal = 16'h3870;
         7'd45:   quarterVal = 16'h3929;
         7'd46:   quarterVal = 16'h39da;
         7'd47:   quarterVal = 16'h3a81;
         7'd48:   quarterVal = 16'h3b1f;
         7'd49:   quarterVal = 16'h3bb5;
         7'd50:   quarterVal = 16'h3c41;
         7'd51:   quarterVal = 16'h3cc4;
         7'd52:   quarterVal = 16'h3d3d;
         7'd53:   quarterVal = 16'h3dad;
         7'd54:   quarterVal = 16'h3e14;
         7'd55:   quarterVal = 16'h3e70;
         7'd56:   quarterVal = 16'h3ec4;
         7'd57:   quarterVal = 16'h3f0d;
         7'd58:   quarterVal = 16'h3f4d;
         7'd59:   quarterVal = 16'h3f83;
         7'd60:   quarterVal = 16'h3fb0;
         7'd61:   quarterVal = 16'h3fd2;
         7'd62:   quarterVal = 16'h3feb;
         7'd63:   quarterVal = 16'h3ffa;
         7'd64:   quarterVal = 16'h3fff;   // Peak, only reached by mirroring
         default: quarterVal = 16'h0000;
      endcase
   end

   // Lower half of the circle is the negated upper half
   always_ff @(posedge AUD_DACLRCK) begin
      sine <= address[7] ? -quarterVal : quarterVal;
   end

endmodule

//--- rtl/ddsVoice.sv
// -------------------------------------------------------------------
// Single DDS voice. Phase accumulator plus two table lookups, the
// second one a quarter turn ahead. Output is silent one cycle after
// the phase was held off.
// -------------------------------------------------------------------
`timescale 1ns/1ns

module ddsVoice (
   input  logic               AUD_DACLRCK,
   input  logic               rstN,
   input  synthPkg::freqWordT freqWord,
   input  logic               enable,
   output synthPkg::voiceOutT voiceOut
);

   synthPkg::phaseT   phase;
   synthPkg::romAddrT sineAddr;
   synthPkg::romAddrT cosAddr;
   synthPkg::sampleT  sineVal;
   synthPkg::sampleT  cosVal;
   logic              phaseOn;   // Stored phase came from an enabled voice
   logic              outOn;     // Same flag, aligned with table output

   always_ff @(posedge AUD_DACLRCK) begin
      if (!rstN) begin
         phase   <= '0;
         phaseOn <= 1'b0;
         outOn   <= 1'b0;
      end else begin
         // Disabled voice parks at phase zero, restarts from there
         phase   <= enable ? phase + (synthPkg::phaseT'(freqWord) << synthPkg::FreqShift)
                           : '0;
         phaseOn <= enable;
         outOn   <= phaseOn;
      end
   end

   assign sineAddr = phase[synthPkg::PhaseWidth-1 -: synthPkg::AddrWidth];
   assign cosAddr  = synthPkg::romAddrT'(sineAddr + synthPkg::QuadOffset);   // Wraps at 256

   sineRom i_sineRom (.AUD_DACLRCK(AUD_DACLRCK), .address(sineAddr), .sine(sineVal));
   sineRom i_cosRom  (.AUD_DACLRCK(AUD_DACLRCK), .address(cosAddr),  .sine(cosVal));

   assign voiceOut.sine   = outOn ? sineVal : '0;
   assign voiceOut.cosine = outOn ? cosVal  : '0;   // cos(0) is not zero, gate it

endmodule

//--- rtl/voiceMixer.sv
// -------------------------------------------------------------------
// Mixes all voices into the stereo pair. Sine outputs go left,
// quadrature outputs go right; the sums are scaled back to 16 bits.
// -------------------------------------------------------------------
`timescale 1ns/1ns

module voiceMixer (
   input  logic               AUD_DACLRCK,
   input  logic               rstN,
   input  synthPkg::voiceOutT voiceOuts [synthPkg::NumVoices],
   output synthPkg::sampleT   audioL,
   output synthPkg::sampleT   audioR
);

   // Two guard bits cover four full-scale voices
   typedef logic signed [$bits(synthPkg::sampleT)+1:0] sumT;

   sumT sumL;
   sumT sumR;

   always_comb begin
      sumL = '0;
      sumR = '0;
      for (int v = 0; v < synthPkg::NumVoices; v++) begin
         sumL = sumL + sumT'(voiceOuts[v].sine);     // Sign-extended
         sumR = sumR + sumT'(voiceOuts[v].cosine);
      end
   end

   always_ff @(posedge AUD_DACLRCK) begin
      if (!rstN) begin
         audioL <= '0;
         audioR <= '0;
      end else begin
         audioL <= synthPkg::sampleT'(sumL >>> synthPkg::MixShift);   // Quarter-sum
         audioR <= synthPkg::sampleT'(sumR >>> synthPkg::MixShift);
      end
   end

endmodule

//--- rtl/synthesizer.sv
// -------------------------------------------------------------------
// Four-voice DDS synthesizer, top level. Voices are programmed over
// AXI4-Lite; a stereo sample leaves on every AUD_DACLRCK edge.
// -------------------------------------------------------------------
`timescale 1ns/1ns

module synthesizer (
   input  logic                   AUD_DACLRCK,   // Sample clock, bus too
   input  logic                   rstN,
   input  axiLitePkg::axiLiteReqT busReq,
   output axiLitePkg::axiLiteRspT busRsp,
   output synthPkg::sampleT       audioL,        // Sum of sines
   output synthPkg::sampleT       audioR         // Sum of quadrature outputs
);

   synthPkg::freqWordT             freqWords [synthPkg::NumVoices];
   logic [synthPkg::NumVoices-1:0] enableMask;
   synthPkg::voiceOutT             voiceOuts [synthPkg::NumVoices];

   voiceRegs i_voiceRegs (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rstN        (rstN),
      .busReq      (busReq),
      .busRsp      (busRsp),
      .freqWords   (freqWords),
      .enableMask  (enableMask)
   );

   // Voice array, one enable bit each
   for (genvar v = 0; v < synthPkg::NumVoices; v++) begin : gVoice
      ddsVoice i_ddsVoice (
         .AUD_DACLRCK (AUD_DACLRCK),
         .rstN        (rstN),
         .freqWord    (freqWords[v]),
         .enable      (enableMask[v]),
         .voiceOut    (voiceOuts[v])
      );
   end

   voiceMixer i_voiceMixer (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rstN        (rstN),
      .voiceOuts   (voiceOuts),
      .audioL      (audioL),
      .audioR      (audioR)
   );

endmodule

//--- bench/synthesizer_assert.sv
// ----------------------------------------------------------------------
// Bus handshake and silence properties, bound into the synthesizer top
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module synthesizerAssert (
   input logic                           AUD_DACLRCK,
   input logic                           rstN,
   input axiLitePkg::axiLiteReqT         busReq,
   input axiLitePkg::axiLiteRspT         busRsp,
   input synthPkg::sampleT               audioL,
   input synthPkg::sampleT               audioR,
   input logic [synthPkg::NumVoices-1:0] enableMask
);

   // Write response waits for the master
   bHold: assert property (@(posedge AUD_DACLRCK) disable iff (!rstN)
      busRsp.bvalid && !busReq.bready |=> busRsp.bvalid)
      else $error("bvalid dropped before bready");

   // Read data frozen while rready is low
   rHold: assert property (@(posedge AUD_DACLRCK) disable iff (!rstN)
      busRsp.rvalid && !busReq.rready |=> busRsp.rvalid && $stable(busRsp.rdata))
      else $error("rvalid or rdata changed before rready");

   // Phase, table and mixer stages drain in two edges
   silence: assert property (@(posedge AUD_DACLRCK) disable iff (!rstN)
      (enableMask == '0) [*2] |-> ##2 (audioL == '0 && audioR == '0))
      else $error("audio not silent with all voices off");

endmodule

bind synthesizer synthesizerAssert i_synthesizerAssert (.*);

//--- bench/tbSynthesizer.sv
// ----------------------------------------------------------------------
// Testbench for the synthesizer. Runs the lines of synthCases.txt as
// bus writes, bus reads and audio sample checks
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tbSynthesizer;

   localparam int Period   = 40;
   localparam int MaxCases = 64;

   logic                   AUD_DACLRCK;
   logic                   rstN;
   axiLitePkg::axiLiteReqT busReq;
   axiLitePkg::axiLiteRspT busRsp;
   synthPkg::sampleT       audioL;
   synthPkg::sampleT       audioR;

   logic [31:0] caseMem [0:6*MaxCases-1];   // Six words per case
   int          cycleCount  = 0;            // Rising edges so far
   int          lastResp    = 0;            // Edge of last bus handshake
   int          limitCycles = 0;
   int          seed        = 32'h4816_b705;

   synthesizer i_synthesizer (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rstN        (rstN),
      .busReq      (busReq),
      .busRsp      (busRsp),
      .audioL      (audioL),
      .audioR      (audioR)
   );

   initial begin
      AUD_DACLRCK = 1'b0;
      forever begin
         #(Period/2);
         cycleCount  = cycleCount + 1;   // Counted before the edge wakes anyone
         AUD_DACLRCK = 1'b1;
         #(Period/2);
         AUD_DACLRCK = 1'b0;
      end
   end

   // ----------------------------------------------------------------------
   // Failure reporting
   // ----------------------------------------------------------------------
   task automatic failRun(input string reason);
      $display("%s", reason);
      $display("Simulation FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Mismatch at %0t ns: %s actual %h expected %h",
                  $time, name, actual, expected);
         failRun("Check failed");
      end
   endtask

   initial begin
      wait (limitCycles > 0);
      #(limitCycles * Period);
      failRun("Timeout: the cases did not finish in the allowed cycles");
   end

   // ----------------------------------------------------------------------
   // Bus tasks, all entered and left 5 ns after an edge
   // ----------------------------------------------------------------------
   task automatic sendWrite(input logic [7:0] addr, input logic [31:0] data);
      logic hs;
      busReq.awaddr  = addr;
      busReq.wdata   = data;
      busReq.awvalid = 1'b1;
      busReq.wvalid  = 1'b1;
      do begin
         #10 hs = busRsp.awready;   // Mid-cycle, ready is combinational
         if (hs) checkValue("wready", busRsp.wready, 1);   // Raised with awready
         @(posedge AUD_DACLRCK);
         if (hs) lastResp = cycleCount;
         #5;
      end while (!hs);
      busReq.awvalid = 1'b0;
      busReq.wvalid  = 1'b0;
   endtask

   task automatic takeWriteResp(input int stall, input logic [1:0] expResp);
      repeat (stall) begin
         @(posedge AUD_DACLRCK);
         #5;
      end
      busReq.bready = 1'b1;
      #10;
      checkValue("bvalid", busRsp.bvalid, 1);
      checkValue("bresp", busRsp.bresp, expResp);
      @(posedge AUD_DACLRCK);
      #5 busReq.bready = 1'b0;
   endtask

   task automatic readCheck(input logic [7:0] addr, input logic [31:0] expData,
                            input logic [1:0] expResp);
      logic hs;
      busReq.araddr  = addr;
      busReq.arvalid = 1'b1;
      do begin
         #10 hs = busRsp.arready;
         @(posedge AUD_DACLRCK);
         if (hs) lastResp = cycleCount;
         #5;
      end while (!hs);
      busReq.arvalid = 1'b0;
      @(posedge AUD_DACLRCK);   // One edge with rready low, response must hold
      #5 busReq.rready = 1'b1;
      #10;
      checkValue("rvalid", busRsp.rvalid, 1);
      checkValue("rdata", busRsp.rdata, expData);
      checkValue("rresp", busRsp.rresp, expResp);
      @(posedge AUD_DACLRCK);
      #5 busReq.rready = 1'b0;
   endtask

   // Second write held off while the first response is stalled
   task automatic stalledWrite(input logic [7:0] addr, input logic [31:0] first,
                               input int stall, input logic [31:0] second);
      sendWrite(addr, first);
      busReq.wdata   = second;
      busReq.awvalid = 1'b1;
      busReq.wvalid  = 1'b1;
      repeat (stall) begin
         #10;
         checkValue("awready", busRsp.awready, 0);
         checkValue("wready", busRsp.wready, 0);
         checkValue("bvalid", busRsp.bvalid, 1);
         @(posedge AUD_DACLRCK);
         #5;
      end
      takeWriteResp(0, axiLitePkg::RespOkay);
      sendWrite(addr, second);
      takeWriteResp(0, axiLitePkg::RespOkay);
   endtask

   task automatic sampleAudio(input int edges, input logic [15:0] expL,
                              input logic [15:0] expR);
      int target;
      target = lastResp + edges;
      if (cycleCount > target) failRun("Sample edge had already passed");
      while (cycleCount < target) @(posedge AUD_DACLRCK);
      #10;   // Value stored at the target edge
      checkValue("audioL", {16'h0, audioL}, {16'h0, expL});
      checkValue("audioR", {16'h0, audioR}, {16'h0, expR});
      @(posedge AUD_DACLRCK);
      #5;
   endtask

   // ----------------------------------------------------------------------
   // Case loop
   // ----------------------------------------------------------------------
   initial begin
      int          sum;
      logic [31:0] kind;
      rstN   = 1'b0;
      busReq = '0;
      sum    = 200;
      for (int i = 0; i < 6*MaxCases; i++) caseMem[i] = '0;
      $readmemh("bench/synthCases.txt", caseMem);
      for (int i = 0; i < MaxCases; i++) begin
         if (caseMem[6*i] == 3 || caseMem[6*i] == 4) sum += caseMem[6*i+3];
      end
      limitCycles = sum;
      repeat (5) @(posedge AUD_DACLRCK);
      #5 rstN = 1'b1;
      lastResp = cycleCount;   // Samples before any bus traffic count from here
      for (int i = 0; i < MaxCases; i++) begin
         kind = caseMem[6*i];
         if (kind == 0) break;
         case (kind)
            1: begin
               sendWrite(caseMem[6*i+1][7:0], caseMem[6*i+2]);
               takeWriteResp($unsigned($random(seed)) % 4, caseMem[6*i+5][1:0]);
            end
            2: readCheck(caseMem[6*i+1][7:0], caseMem[6*i+2], caseMem[6*i+5][1:0]);
            3: sampleAudio(caseMem[6*i+3], caseMem[6*i+4][15:0], caseMem[6*i+5][15:0]);
            4: stalledWrite(caseMem[6*i+1][7:0], caseMem[6*i+2], caseMem[6*i+3],
                            caseMem[6*i+4]);
            default: failRun($sformatf("Unknown case kind %0d in case %0d", kind, i));
         endcase
      end
      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- files.f
rtl/synthPkg.sv
rtl/axiLitePkg.sv
rtl/voiceRegs.sv
rtl/sineRom.sv
rtl/ddsVoice.sv
rtl/voiceMixer.sv
rtl/synthesizer.sv
bench/synthesizer_assert.sv
bench/tbSynthesizer.sv

//--- bench/synthCases.txt
// kind addr data cycles expA expB, hex. kind 1 write (expB bresp), 2 read (data expected,
// expB rresp), 3 sample (cycles after last handshake, expA audioL, expB audioR), 4 stall, 0 end
3 00 00000000 3 0000 0000
2 00 00000000 0 0 0
2 04 00000000 0 0 0
2 08 00000000 0 0 0
2 0C 00000000 0 0 0
2 10 00000000 0 0 0
1 10 FFFFFFF0 0 0 0
2 10 00000000 0 0 0
1 04 12345678 0 0 0
2 04 00005678 0 0 0
1 20 00000001 0 0 2
2 20 00000000 0 0 2
2 02 00000000 0 0 2
1 04 00000000 0 0 0
1 00 00004000 0 0 0
1 10 00000001 0 0 0
3 00 00000000 5 0EC7 061F
3 00 00000000 8 0B50 F4B0
3 00 00000000 E F000 0000
1 10 00000000 0 0 0
3 00 00000000 5 0000 0000
1 04 00008000 0 0 0
1 08 00002000 0 0 0
1 0C 0000C000 0 0 0
1 10 0000001F 0 0 0
3 00 00000000 5 1CDB F954
3 00 00000000 6 0B50 FB50
1 10 00000000 0 0 0
3 00 00000000 5 0000 0000
1 10 00000001 0 0 0
3 00 00000000 5 0EC7 061F
4 08 00000111 4 00000222 0
2 08 00000222 0 0 0
0 00 00000000 0 0 0
